// File: char_layer/char_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defs.svh"

module char_layer (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire [8:0]              h,
    input  wire [8:0]              v,
    output logic [4:0]             map_idx,
    input  wire [7:0]              map_code,
    output logic                   gfx_req,
    output logic [`ROM_AW-1:0]     gfx_addr,
    input  wire                    gfx_ready,
    input  wire vid_pkg::char_row_t gfx_row,
    output vid_pkg::pix_t          pix
);

    logic [9:0] hx_map;     // Pixel whose tile code is read now
    logic [9:0] hx_row;     // Pixel whose row is requested now
    logic [8:0] v_nxt;
    logic [8:0] v_map;
    logic [8:0] v_row;
    logic [1:0] nxt_attr;
    logic [1:0] cur_attr;
    logic [7:0] sh1;
    logic [7:0] sh0;
    logic       row_ok;

    assign hx_map = {1'b0, h} + 10'd9;
    assign hx_row = {1'b0, h} + 10'd8;
    assign v_nxt  = (v == 9'(`VID_VTOTAL - 1)) ? 9'd0 : v + 9'd1;
    assign v_map  = (hx_map >= 10'(`VID_HTOTAL)) ? v_nxt : v;   // Wraps into next line
    assign v_row  = (hx_row >= 10'(`VID_HTOTAL)) ? v_nxt : v;

    // Code arrives one clk later, on the tile boundary
    assign map_idx = 5'(v_map[4:3] * `VID_MAP_COLS + hx_map[5:3]);

    assign gfx_req  = (h[2:0] == 3'd0);
    assign gfx_addr = `ROM_CHAR_BASE + `ROM_AW'({map_code[5:0], v_row[2:0]});

    always_ff @(posedge clk) begin
        if (h[2:0] == 3'd0) begin
            nxt_attr <= map_code[7:6];
        end
        if (h[2:0] == 3'd7) begin
            sh1      <= gfx_row.plane1;
            sh0      <= gfx_row.plane0;
            cur_attr <= nxt_attr;
        end else begin
            sh1 <= {sh1[6:0], 1'b0};
            sh0 <= {sh0[6:0], 1'b0};
        end
    end

    // Row missing at the boundary shows as an invalid tile
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_ok <= 1'b0;
        end else if (h[2:0] == 3'd7) begin
            row_ok <= gfx_ready;
        end
    end

    assign pix = '{attr: cur_attr, colour: {sh1[7], sh0[7]}, valid: row_ok};

endmodule

`default_nettype wire

// File: common/vid_defs.svh
`ifndef VID_DEFS_SVH
`define VID_DEFS_SVH

// Raster, shrunk for short simulations
`define VID_HTOTAL    64
`define VID_HVIS      48
`define VID_VTOTAL    32
`define VID_VVIS      24
`define VID_HS_START  52
`define VID_HS_END    58
`define VID_VS_START  26
`define VID_VS_END    28

// Tile map, 8x8 pixel tiles
`define VID_MAP_COLS  8
`define VID_MAP_ROWS  4

`define ROM_AW        22
`define ROM_CHAR_BASE 22'h0C000   // Word address of char graphics

// Host address decode
`define HB_CHAR_LO    12'h000
`define HB_CHAR_HI    12'h01F
`define HB_PAL_LO     12'h040
`define HB_PAL_HI     12'h04F
`define HB_ROM_LO     12'h800    // Up to 12'hFFF

`endif

// File: common/vid_pkg.sv
`default_nettype none

package vid_pkg;

    // Wishbone classic request from the host
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [11:0] adr;   // Word address
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    typedef logic [15:0] rom_word_t;

    // One 8-pixel tile row, plane1 in the upper byte of the ROM word
    typedef struct packed {
        logic [7:0] plane1;
        logic [7:0] plane0;
    } char_row_t;

    typedef struct packed {
        logic [1:0] attr;   // Palette bank
        logic [1:0] colour;
        logic       valid;
    } pix_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage

`default_nettype wire

// File: design/color_mix.sv
`timescale 1ns/1ps
`default_nettype none

module color_mix (
    input  wire                clk,
    input  wire                arst_n,
    input  wire vid_pkg::pix_t pix,
    input  wire                lhbl,
    input  wire                lvbl,
    input  wire                pal_we,
    input  wire [3:0]          pal_addr,
    input  wire vid_pkg::rgb_t pal_data,
    output vid_pkg::rgb_t      rgb,
    output logic               lhbl_dly,
    output logic               lvbl_dly
);

    vid_pkg::rgb_t pal [16];   // Indexed by {attr, colour}
    logic          show;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal[pal_addr] <= pal_data;
        end
    end

    assign show = lhbl && lvbl && pix.valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb      <= '0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
        end else begin
            rgb      <= show ? pal[{pix.attr, pix.colour}] : '0;   // Black in blanking
            lhbl_dly <= lhbl;
            lvbl_dly <= lvbl;
        end
    end

endmodule

`default_nettype wire

// File: design/vid_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defs.svh"

module vid_timer (
    input  wire        clk,
    input  wire        arst_n,
    output logic [8:0] h,
    output logic [8:0] v,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs
);

    logic h_last;
    logic v_last;

    assign h_last = (h == 9'(`VID_HTOTAL - 1));
    assign v_last = (v == 9'(`VID_VTOTAL - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h <= 9'd0;
            v <= 9'd0;
        end else begin
            h <= h_last ? 9'd0 : h + 9'd1;
            if (h_last) begin
                v <= v_last ? 9'd0 : v + 9'd1;
            end
        end
    end

    // Blanking follows the counters directly
    assign lhbl = (h < 9'(`VID_HVIS));
    assign lvbl = (v < 9'(`VID_VVIS));

    // Syncs one clk late, in step with the delayed blanking at the mixer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hs <= 1'b0;
            vs <= 1'b0;
        end else begin
            hs <= (h >= 9'(`VID_HS_START)) && (h < 9'(`VID_HS_END));
            vs <= (v >= 9'(`VID_VS_START)) && (v < 9'(`VID_VS_END));
        end
    end

    a_h_range: assert property (@(posedge clk) disable iff (!arst_n)
        h < 9'(`VID_HTOTAL));

endmodule

`default_nettype wire

// File: design/vid_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defs.svh"

module vid_top (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire vid_pkg::wb_req_t   wb_req,
    output vid_pkg::wb_rsp_t        wb_rsp,
    output logic                    rom_req,
    output logic [`ROM_AW-1:0]      rom_addr,
    input  wire                     rom_valid,
    input  wire vid_pkg::rom_word_t rom_data,
    output vid_pkg::rgb_t           rgb,
    output logic                    lhbl,
    output logic                    lvbl,
    output logic                    hs,
    output logic                    vs
);

    logic [8:0]         h;
    logic [8:0]         v;
    logic               lhbl_raw;
    logic               lvbl_raw;
    logic [4:0]         map_idx;
    logic [7:0]         map_code;
    logic               pal_we;
    logic [3:0]         pal_addr;
    vid_pkg::rgb_t      pal_data;
    logic               rom_rd_req;
    logic [10:0]        rom_rd_addr;
    logic               host_ready;
    vid_pkg::rom_word_t host_word;
    logic               gfx_req;
    logic [`ROM_AW-1:0] gfx_addr;
    logic               gfx_ready;
    vid_pkg::char_row_t gfx_row;
    logic               char_req;
    logic [`ROM_AW-1:0] char_addr;
    logic               host_req;
    logic [`ROM_AW-1:0] host_addr;
    logic               char_done;
    logic               host_done;
    vid_pkg::rom_word_t arb_word;
    vid_pkg::pix_t      pix;

    // Syncs come out of the timer already registered
    vid_timer u_timer (
        .clk(clk), .arst_n(arst_n), .h(h), .v(v),
        .lhbl(lhbl_raw), .lvbl(lvbl_raw), .hs(hs), .vs(vs)
    );

    host_bus u_host (
        .clk(clk), .arst_n(arst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .map_idx(map_idx), .map_code(map_code),
        .pal_we(pal_we), .pal_addr(pal_addr), .pal_data(pal_data),
        .rom_rd_req(rom_rd_req), .rom_rd_addr(rom_rd_addr),
        .rom_rd_done(host_ready), .rom_rd_data(host_word)
    );

    rom_slot #(.data_t(vid_pkg::rom_word_t)) u_host_slot (
        .clk(clk), .arst_n(arst_n),
        .req_in(rom_rd_req), .addr_in({{(`ROM_AW - 11){1'b0}}, rom_rd_addr}),
        .req(host_req), .addr(host_addr), .done_in(host_done), .word(arb_word),
        .ready(host_ready), .data(host_word)
    );

    rom_slot #(.data_t(vid_pkg::char_row_t)) u_char_slot (
        .clk(clk), .arst_n(arst_n), .req_in(gfx_req), .addr_in(gfx_addr),
        .req(char_req), .addr(char_addr), .done_in(char_done), .word(arb_word),
        .ready(gfx_ready), .data(gfx_row)
    );

    rom_arbiter u_arb (
        .clk(clk), .arst_n(arst_n),
        .char_req(char_req), .char_addr(char_addr),
        .host_req(host_req), .host_addr(host_addr),
        .char_done(char_done), .host_done(host_done), .word(arb_word),
        .rom_req(rom_req), .rom_addr(rom_addr), .rom_valid(rom_valid), .rom_data(rom_data)
    );

    char_layer u_char (
        .clk(clk), .arst_n(arst_n), .h(h), .v(v),
        .map_idx(map_idx), .map_code(map_code), .gfx_req(gfx_req), .gfx_addr(gfx_addr),
        .gfx_ready(gfx_ready), .gfx_row(gfx_row), .pix(pix)
    );

    color_mix u_mix (
        .clk(clk), .arst_n(arst_n), .pix(pix), .lhbl(lhbl_raw), .lvbl(lvbl_raw),
        .pal_we(pal_we), .pal_addr(pal_addr), .pal_data(pal_data),
        .rgb(rgb), .lhbl_dly(lhbl), .lvbl_dly(lvbl)
    );

endmodule

`default_nettype wire

// File: host_bus/host_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defs.svh"

module host_bus (
    input  wire                clk,
    input  wire                arst_n,
    input  wire vid_pkg::wb_req_t wb_req,
    output vid_pkg::wb_rsp_t   wb_rsp,
    input  wire [4:0]          map_idx,
    output logic [7:0]         map_code,
    output logic               pal_we,
    output logic [3:0]         pal_addr,
    output vid_pkg::rgb_t      pal_data,
    output logic               rom_rd_req,
    output logic [10:0]        rom_rd_addr,
    input  wire                rom_rd_done,
    input  wire vid_pkg::rom_word_t rom_rd_data
);

    logic [7:0]  char_ram [`VID_MAP_COLS * `VID_MAP_ROWS];
    logic        ack;
    logic        busy;      // ROM read in flight
    logic [15:0] rdat;
    logic        start;
    logic [11:0] char_off;
    logic [11:0] pal_off;
    logic        in_char;
    logic        in_pal;
    logic        in_rom;

    assign char_off = wb_req.adr - `HB_CHAR_LO;
    assign pal_off  = wb_req.adr - `HB_PAL_LO;
    assign in_char  = (char_off <= (`HB_CHAR_HI - `HB_CHAR_LO));
    assign in_pal   = (pal_off <= (`HB_PAL_HI - `HB_PAL_LO));
    assign in_rom   = (wb_req.adr >= `HB_ROM_LO);

    // New cycle, not while acking or waiting on the ROM
    assign start = wb_req.cyc && wb_req.stb && !ack && !busy;

    assign rom_rd_req  = start && in_rom && !wb_req.we;
    assign rom_rd_addr = 11'(wb_req.adr - `HB_ROM_LO);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack    <= 1'b0;
            busy   <= 1'b0;
            pal_we <= 1'b0;
        end else begin
            ack    <= 1'b0;
            pal_we <= 1'b0;
            if (rom_rd_req) begin
                busy <= 1'b1;
            end else if (start) begin
                ack    <= 1'b1;   // RAM, palette, ROM writes and holes
                pal_we <= wb_req.we && in_pal;
            end else if (busy && rom_rd_done) begin
                busy <= 1'b0;
                ack  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && wb_req.we && in_char) begin
            char_ram[char_off[4:0]] <= wb_req.dat[7:0];
        end
        if (start) begin
            rdat     <= (in_char && !wb_req.we) ? {8'h00, char_ram[char_off[4:0]]} : 16'h0000;
            pal_addr <= pal_off[3:0];
            pal_data <= vid_pkg::rgb_t'(wb_req.dat[11:0]);
        end else if (busy && rom_rd_done) begin
            rdat <= rom_rd_data;
        end
        map_code <= char_ram[map_idx];   // Tile layer port
    end

    assign wb_rsp = '{ack: ack, dat: rdat};

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb);
    a_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
        wb_rsp.ack |=> !wb_rsp.ack);

endmodule

`default_nettype wire

// File: rom_ctrl/rom_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defs.svh"

module rom_arbiter (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     char_req,
    input  wire [`ROM_AW-1:0]       char_addr,
    input  wire                     host_req,
    input  wire [`ROM_AW-1:0]       host_addr,
    output logic                    char_done,
    output logic                    host_done,
    output vid_pkg::rom_word_t      word,
    output logic                    rom_req,
    output logic [`ROM_AW-1:0]      rom_addr,
    input  wire                     rom_valid,
    input  wire vid_pkg::rom_word_t rom_data
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t state;
    logic   gnt_char;   // Owner of the current transaction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            gnt_char <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (char_req || host_req) begin
                        state    <= ST_BUSY;
                        gnt_char <= char_req;   // Char layer wins ties
                    end
                end
                ST_BUSY: begin
                    if (rom_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            rom_addr <= char_req ? char_addr : host_addr;
        end
    end

    assign rom_req   = (state == ST_BUSY);
    assign char_done = rom_req && rom_valid && gnt_char;
    assign host_done = rom_req && rom_valid && !gnt_char;
    assign word      = rom_data;   // Slots register it themselves

    a_one_done: assert property (@(posedge clk) disable iff (!arst_n)
        !(char_done && host_done));

endmodule

`default_nettype wire

// File: rom_ctrl/rom_slot.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defs.svh"

module rom_slot #(
    parameter type data_t = vid_pkg::rom_word_t
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   req_in,
    input  wire [`ROM_AW-1:0]     addr_in,
    output logic                  req,
    output logic [`ROM_AW-1:0]    addr,
    input  wire                   done_in,
    input  wire vid_pkg::rom_word_t word,
    output logic                  ready,
    output data_t                 data
);

    logic               pending;
    logic [`ROM_AW-1:0] addr_q;

    // A fresh request reaches the arbiter in the same cycle
    assign req  = req_in || pending;
    assign addr = req_in ? addr_in : addr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            ready   <= 1'b0;
        end else if (req_in) begin
            pending <= 1'b1;
            ready   <= 1'b0;   // Old data is stale now
        end else if (done_in) begin
            pending <= 1'b0;
            ready   <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_in) begin
            addr_q <= addr_in;
        end
        if (done_in) begin
            data <= data_t'(word);
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_vid_top -o tb_vid_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_vid_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
fi
exit 1

// File: sim.f
+incdir+common
common/vid_pkg.sv
design/vid_timer.sv
host_bus/host_bus.sv
rom_ctrl/rom_slot.sv
rom_ctrl/rom_arbiter.sv
char_layer/char_layer.sv
design/color_mix.sv
design/vid_top.sv
tb/rom_model.sv
tb/tb_vid_top.sv

// File: tb/rom_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defs.svh"

module rom_model (
    input  wire                clk,
    input  wire                arst_n,
    input  wire                rom_req,
    input  wire [`ROM_AW-1:0]  rom_addr,
    output logic               rom_valid,
    output vid_pkg::rom_word_t rom_data
);

    logic [31:0] lfsr;
    logic        busy;      // Transaction accepted, answer pending
    int          cnt;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Outputs change on the falling edge only
    always @(negedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rom_valid <= 1'b0;
            rom_data  <= '0;
            busy = 1'b0;
            cnt  = 0;
            lfsr = 32'h4435_b053;
        end else begin
            rom_valid <= 1'b0;
            if (rom_req && !rom_valid) begin
                if (!busy) begin
                    lfsr = lfsr_step(lfsr);
                    cnt  = 2 * int'(lfsr[0]);
                    lfsr = lfsr_step(lfsr);
                    cnt  = (cnt + int'(lfsr[0])) % 3 + 1;   // 1 to 3 cycles
                    busy = 1'b1;
                end
                cnt = cnt - 1;
                if (cnt == 0) begin
                    rom_valid <= 1'b1;
                    rom_data  <= {rom_addr[7:0], ~rom_addr[7:0]};
                    busy = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_vid_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_defs.svh"

module tb_vid_top;

    localparam int N_MAP    = `VID_MAP_COLS * `VID_MAP_ROWS;
    localparam int N_ROM_RD = 8;
    localparam int N_OPS    = 2 * N_MAP + 16 + N_ROM_RD + 3;
    localparam int FRAME    = `VID_HTOTAL * `VID_VTOTAL;
    localparam int LIMIT    = N_OPS * 20 + 3 * FRAME;

    logic               clk;
    logic               arst_n;
    vid_pkg::wb_req_t   wb_req;
    vid_pkg::wb_rsp_t   wb_rsp;
    logic               rom_req;
    logic [`ROM_AW-1:0] rom_addr;
    logic               rom_valid;
    vid_pkg::rom_word_t rom_data;
    vid_pkg::rgb_t      rgb;
    logic               lhbl;
    logic               lvbl;
    logic               hs;
    logic               vs;

    // Bus operations and expected read data
    logic        op_we  [N_OPS];
    logic [11:0] op_adr [N_OPS];
    logic [15:0] op_dat [N_OPS];
    logic [15:0] op_exp [N_OPS];
    logic [7:0]  map_sh [N_MAP];   // Tile codes held by the DUT
    logic [11:0] pal_sh [16];

    int   err_cnt = 0;
    int   chk_cnt = 0;
    int   pix_err = 0;
    int   pix_chk = 0;
    int   cycles = 0;
    int   frames_seen = 0;
    int   x = 0;
    int   y = 0;
    int   vis_cnt = 0;
    int   hs_cnt = 0;
    int   vs_cnt = 0;
    logic watch = 1'b0;
    logic armed = 1'b0;
    logic lhbl_q = 1'b0;
    logic lvbl_q = 1'b0;
    logic hs_q = 1'b0;
    logic vs_q = 1'b0;

    vid_top u_dut (
        .clk(clk), .arst_n(arst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .rom_req(rom_req), .rom_addr(rom_addr), .rom_valid(rom_valid), .rom_data(rom_data),
        .rgb(rgb), .lhbl(lhbl), .lvbl(lvbl), .hs(hs), .vs(vs)
    );

    rom_model u_rom (
        .clk(clk), .arst_n(arst_n), .rom_req(rom_req), .rom_addr(rom_addr),
        .rom_valid(rom_valid), .rom_data(rom_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Checks: %0d, errors: %0d", chk_cnt + pix_chk, err_cnt + pix_err + 1);
            $display("Test failed");
            $finish;
        end
    end

    task automatic set_op(input int k, input logic we, input logic [11:0] adr,
                          input logic [15:0] dat, input logic [15:0] exp);
        op_we[k]  = we;
        op_adr[k] = adr;
        op_dat[k] = dat;
        op_exp[k] = exp;
    endtask

    task automatic build_table();
        int          n;
        logic [10:0] ra;
        for (n = 0; n < N_MAP; n++) begin
            map_sh[n] = 8'(n * 8'h47 + 8'h1b);
            set_op(n, 1'b1, 12'(`HB_CHAR_LO + n), {8'hc3, map_sh[n]}, 16'h0000);
        end
        for (n = 0; n < N_MAP; n++) begin   // Read back in reverse order
            set_op(N_MAP + n, 1'b0, 12'(`HB_CHAR_LO + N_MAP - 1 - n), 16'h0000,
                   {8'h00, map_sh[N_MAP - 1 - n]});
        end
        for (n = 0; n < 16; n++) begin
            pal_sh[n] = 12'(n * 12'h111 + 12'h0a3);
            set_op(2 * N_MAP + n, 1'b1, 12'(`HB_PAL_LO + n), {4'h0, pal_sh[n]}, 16'h0000);
        end
        for (n = 0; n < N_ROM_RD; n++) begin
            ra = 11'(n * 215 + 3);
            set_op(2 * N_MAP + 16 + n, 1'b0, `HB_ROM_LO + {1'b0, ra}, 16'h0000,
                   {ra[7:0], ~ra[7:0]});
        end
        set_op(N_OPS - 3, 1'b1, 12'h900, 16'h1234, 16'h0000);   // ROM write is dropped
        set_op(N_OPS - 2, 1'b0, 12'h100, 16'h0000, 16'h0000);   // Hole
        set_op(N_OPS - 1, 1'b0, `HB_PAL_LO + 12'h001, 16'h0000, 16'h0000);
    endtask

    // One Wishbone classic access, entered and left on a falling edge
    task automatic bus_op(input logic we, input logic [11:0] adr, input logic [15:0] dat,
                          output logic [15:0] rdat);
        int   waited;
        logic acked;
        waited = 0;
        acked  = 1'b0;
        rdat   = 16'h0000;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        while (!acked && waited < 20) begin
            @(negedge clk);
            waited++;
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdat  = wb_rsp.dat;
            end
        end
        @(negedge clk);   // Request stays up through the ack edge
        wb_req = '0;
        chk_cnt += 3;
        assert (acked) else begin
            err_cnt++;
            $display("No ack came within 20 cycles for the access at %h", adr);
        end
        assert (!wb_rsp.ack) else begin
            err_cnt++;
            $display("** Error: wb_rsp.ack is %h one cycle after ack, expected %h", 1'b1, 1'b0);
        end
        assert ((!we && adr >= `HB_ROM_LO) || waited == 1) else begin
            err_cnt++;
            $display("** Error: ack latency at %h is %h cycles, expected %h", adr, waited, 1);
        end
    endtask

    function automatic logic [11:0] expect_rgb(input int px, input int py);
        logic [7:0]         code;
        logic [`ROM_AW-1:0] a;
        logic [7:0]         p1;
        logic [7:0]         p0;
        logic [2:0]         b;
        code = map_sh[5'((py / 8) * `VID_MAP_COLS + px / 8)];
        a    = `ROM_CHAR_BASE + `ROM_AW'(code[5:0]) * `ROM_AW'(8) + `ROM_AW'(py % 8);
        p1   = a[7:0];   // Model word, high byte
        p0   = ~a[7:0];
        b    = 3'(7 - px % 8);
        return pal_sh[{code[7:6], p1[b], p0[b]}];
    endfunction

    // Raster checker, position taken from the output blanking edges
    always @(negedge clk) begin
        if (lhbl && !lhbl_q) begin
            x = 0;
            y = (lvbl && !lvbl_q) ? 0 : y + 1;
        end else begin
            x = x + 1;
        end
        if (armed) begin
            pix_chk++;
            if (lhbl && lvbl) begin
                vis_cnt++;
                assert (rgb == expect_rgb(x, y)) else begin
                    pix_err++;
                    $display("** Error: rgb at (%0d,%0d) is %h, expected %h",
                             x, y, rgb, expect_rgb(x, y));
                end
            end else begin
                assert (rgb == 12'h000) else begin
                    pix_err++;
                    $display("** Error: rgb in blanking is %h, expected %h", rgb, 12'h000);
                end
            end
            if (hs && !hs_q) hs_cnt++;
            if (vs && !vs_q) vs_cnt++;
            if (!lvbl && lvbl_q) begin   // End of the visible area
                pix_chk++;
                assert (vis_cnt == `VID_HVIS * `VID_VVIS) else begin
                    pix_err++;
                    $display("** Error: visible pixels per frame %h, expected %h",
                             vis_cnt, `VID_HVIS * `VID_VVIS);
                end
                if (frames_seen > 0) begin
                    pix_chk += 2;
                    assert (hs_cnt == `VID_VTOTAL && vs_cnt == 1) else begin
                        pix_err++;
                        $display("** Error: hs pulses %h and vs pulses %h, expected %h and %h",
                                 hs_cnt, vs_cnt, `VID_VTOTAL, 1);
                    end
                end
                frames_seen++;
                vis_cnt = 0;
                hs_cnt  = 0;
                vs_cnt  = 0;
                armed   = (frames_seen < 2);
            end
        end else if (watch && frames_seen == 0 && !vs && vs_q) begin
            armed   = 1'b1;
            vis_cnt = 0;
            hs_cnt  = 0;
            vs_cnt  = 0;
        end
        lhbl_q = lhbl;
        lvbl_q = lvbl;
        hs_q   = hs;
        vs_q   = vs;
    end

    initial begin
        logic [15:0] rd;
        int          i;
        wb_req = '0;
        arst_n = 1'b0;
        build_table();
        repeat (3) @(negedge clk);
        chk_cnt++;
        assert (rgb == 12'h000 && !rom_req && !wb_rsp.ack) else begin
            err_cnt++;
            $display("** Error: after reset rgb=%h rom_req=%h wb_rsp.ack=%h, expected 0",
                     rgb, rom_req, wb_rsp.ack);
        end
        arst_n = 1'b1;
        for (i = 0; i < N_OPS; i++) begin
            bus_op(op_we[i], op_adr[i], op_dat[i], rd);
            if (!op_we[i]) begin
                chk_cnt++;
                assert (rd == op_exp[i]) else begin
                    err_cnt++;
                    $display("** Error: wb_rsp.dat at %h is %h, expected %h",
                             op_adr[i], rd, op_exp[i]);
                end
            end
        end
        watch = 1'b1;
        while (frames_seen < 1) @(negedge clk);
        // New palette goes in during vertical blanking
        for (i = 0; i < 16; i++) begin
            bus_op(1'b1, 12'(`HB_PAL_LO + i), {4'h0, pal_sh[i] ^ 12'h5a5}, rd);
        end
        for (i = 0; i < 16; i++) begin
            pal_sh[i] = pal_sh[i] ^ 12'h5a5;
        end
        while (frames_seen < 2) @(negedge clk);
        $display("Checks: %0d, errors: %0d", chk_cnt + pix_chk, err_cnt + pix_err);
        if (err_cnt + pix_err == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
